/* common/rv32_isa_pkg.sv */
`default_nettype none

package rv32_isa_pkg;

    // Datapath word and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the decode stage
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // Branch condition, access size or ALU sub-select, taken as is
    typedef logic [2:0] funct3_t;

    // OP / OP-IMM sub-select
    localparam funct3_t F3_ADD  = 3'd0;
    localparam funct3_t F3_SLL  = 3'd1;
    localparam funct3_t F3_SLT  = 3'd2;
    localparam funct3_t F3_SLTU = 3'd3;
    localparam funct3_t F3_XOR  = 3'd4;
    localparam funct3_t F3_SR   = 3'd5;
    localparam funct3_t F3_OR   = 3'd6;
    localparam funct3_t F3_AND  = 3'd7;

    // M extension sub-select
    localparam funct3_t F3_MUL    = 3'd0;
    localparam funct3_t F3_MULH   = 3'd1;
    localparam funct3_t F3_MULHSU = 3'd2;
    localparam funct3_t F3_MULHU  = 3'd3;
    localparam funct3_t F3_DIV    = 3'd4;
    localparam funct3_t F3_DIVU   = 3'd5;
    localparam funct3_t F3_REM    = 3'd6;
    localparam funct3_t F3_REMU   = 3'd7;

    // SUB / SRA select
    localparam logic [6:0] FUNCT7_ALT    = 7'h20;
    // Multiply / divide select
    localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [4:0]            imm_4_0;
        opcode_t               opcode;
    } s_type_t;

    // Offset bits scattered, bit 0 implied zero
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_t               opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } u_type_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } j_type_t;

    // Same instruction word, one view per encoding format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

endpackage : rv32_isa_pkg

`default_nettype wire

/* common/rv32_ctrl_pkg.sv */
`default_nettype none

package rv32_ctrl_pkg;

    // Operand and result muxes in execute
    typedef enum logic {rs1_out, pc_out} alu1_sel_t;
    typedef enum logic {rs2_out, imm_out} alu2_sel_t;
    typedef enum logic [2:0] {
        alu_out,
        cmp_out,
        addr_out,
        mul_out,
        div_out
    } func_sel_t;
    // Jump target base
    typedef enum logic {pc_op, rs1_op} target_sel_t;
    typedef enum logic {mem_rdata_out, func_out} wb_sel_t;

    // Unit opcode, meaning set by func_sel
    typedef logic [2:0] func_op_t;

    // ALU
    localparam func_op_t alu_add = 3'd0;
    localparam func_op_t alu_sll = 3'd1;
    localparam func_op_t alu_xor = 3'd2;
    localparam func_op_t alu_srl = 3'd3;
    localparam func_op_t alu_or  = 3'd4;
    localparam func_op_t alu_and = 3'd5;
    localparam func_op_t alu_sub = 3'd6;
    localparam func_op_t alu_sra = 3'd7;

    // Comparator, same codes as branch funct3
    localparam func_op_t beq  = 3'b000;
    localparam func_op_t bne  = 3'b001;
    localparam func_op_t blt  = 3'b100;
    localparam func_op_t bge  = 3'b101;
    localparam func_op_t bltu = 3'b110;
    localparam func_op_t bgeu = 3'b111;

    // Multiplier, operand signedness
    localparam func_op_t ss_mul = 3'd0;
    localparam func_op_t su_mul = 3'd1;
    localparam func_op_t uu_mul = 3'd2;

    // Divider, quotient or remainder
    localparam func_op_t ss_div = 3'd0;
    localparam func_op_t uu_div = 3'd1;
    localparam func_op_t ss_rem = 3'd2;
    localparam func_op_t uu_rem = 3'd3;

    typedef struct packed {
        alu1_sel_t   alu1;
        alu2_sel_t   alu2;
        func_sel_t   func_sel;
        target_sel_t target_sel;
        logic        branch;
        func_op_t    func_op;
    } ex_ctrl_t;

    typedef struct packed {
        logic                  mem_read;
        logic                  mem_write;
        rv32_isa_pkg::funct3_t mem_funct3;
    } mem_ctrl_t;

    // Load size again here for write-back extension
    typedef struct packed {
        wb_sel_t               wb_sel;
        rv32_isa_pkg::funct3_t mem_funct3;
        logic                  regf_we;
    } wb_ctrl_t;

    typedef struct packed {
        logic [rv32_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [rv32_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [rv32_isa_pkg::REG_ADDR_W-1:0] rd_addr;
        ex_ctrl_t                            ex;
        mem_ctrl_t                           mem;
        wb_ctrl_t                            wb;
    } dec_ctrl_t;

    // Decode-to-execute pipeline word
    typedef struct packed {
        dec_ctrl_t                     dec;
        logic [rv32_isa_pkg::XLEN-1:0] imm;
    } id_ex_t;

endpackage : rv32_ctrl_pkg

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire rv32_isa_pkg::inst_t          i_inst,
    output logic [rv32_isa_pkg::XLEN-1:0]     o_imm
);

    import rv32_isa_pkg::*;

    // Format picked from opcode, sign always from bit 31
    always_comb begin
        case (i_inst.r.opcode)
            // I-type
            op_jalr, op_load, op_imm: begin
                o_imm = {{(XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
            end
            // S-type, offset split around rs fields
            op_store: begin
                o_imm = {{(XLEN-12){i_inst.s.imm_11_5[6]}},
                         i_inst.s.imm_11_5,
                         i_inst.s.imm_4_0};
            end
            // B-type, halfword aligned
            op_br: begin
                o_imm = {{(XLEN-13){i_inst.b.imm_12}},
                         i_inst.b.imm_12,
                         i_inst.b.imm_11,
                         i_inst.b.imm_10_5,
                         i_inst.b.imm_4_1,
                         1'b0};
            end
            // Upper 20 bits, low 12 cleared
            op_lui, op_auipc: begin
                o_imm = {i_inst.u.imm_31_12, 12'h000};
            end
            // J-type, halfword aligned
            op_jal: begin
                o_imm = {{(XLEN-21){i_inst.j.imm_20}},
                         i_inst.j.imm_20,
                         i_inst.j.imm_19_12,
                         i_inst.j.imm_11,
                         i_inst.j.imm_10_1,
                         1'b0};
            end
            // R-type and unknown carry no immediate
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule : imm_gen

`default_nettype wire

/* decode/ctrl_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  wire rv32_isa_pkg::inst_t  i_inst,
    output rv32_ctrl_pkg::dec_ctrl_t  o_dec
);

    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    always_comb begin
        // Defaults, also the bundle for unknown opcodes
        o_dec.rs1_addr       = '0;
        o_dec.rs2_addr       = '0;
        o_dec.rd_addr        = '0;
        o_dec.ex.alu1        = rs1_out;
        o_dec.ex.alu2        = rs2_out;
        o_dec.ex.func_sel    = alu_out;
        o_dec.ex.target_sel  = pc_op;
        o_dec.ex.branch      = 1'b0;
        o_dec.ex.func_op     = '0;
        o_dec.mem.mem_read   = 1'b0;
        o_dec.mem.mem_write  = 1'b0;
        o_dec.mem.mem_funct3 = '0;
        o_dec.wb.wb_sel      = mem_rdata_out;
        o_dec.wb.mem_funct3  = '0;
        o_dec.wb.regf_we     = 1'b0;

        case (i_inst.r.opcode)
            // rd = 0 + imm
            op_lui: begin
                o_dec.rd_addr    = i_inst.u.rd;
                o_dec.ex.alu2    = imm_out;
                o_dec.ex.func_op = alu_add;
                o_dec.wb.wb_sel  = func_out;
                o_dec.wb.regf_we = 1'b1;
            end
            // rd = pc + imm
            op_auipc: begin
                o_dec.rd_addr    = i_inst.u.rd;
                o_dec.ex.alu1    = pc_out;
                o_dec.ex.alu2    = imm_out;
                o_dec.ex.func_op = alu_add;
                o_dec.wb.wb_sel  = func_out;
                o_dec.wb.regf_we = 1'b1;
            end
            // x0 == x0 under beq, so always taken
            op_jal: begin
                o_dec.rd_addr     = i_inst.j.rd;
                o_dec.ex.func_op  = beq;
                o_dec.ex.func_sel = addr_out;
                o_dec.ex.branch   = 1'b1;
                o_dec.wb.wb_sel   = func_out;
                o_dec.wb.regf_we  = 1'b1;
            end
            // Same register on both compare ports, taken; target from rs1
            op_jalr: begin
                o_dec.rs1_addr      = i_inst.i.rs1;
                o_dec.rs2_addr      = i_inst.i.rs1;
                o_dec.rd_addr       = i_inst.i.rd;
                o_dec.ex.func_op    = beq;
                o_dec.ex.func_sel   = addr_out;
                o_dec.ex.target_sel = rs1_op;
                o_dec.ex.branch     = 1'b1;
                o_dec.wb.wb_sel     = func_out;
                o_dec.wb.regf_we    = 1'b1;
            end
            // Condition code passed straight to comparator
            op_br: begin
                o_dec.rs1_addr   = i_inst.b.rs1;
                o_dec.rs2_addr   = i_inst.b.rs2;
                o_dec.ex.func_op = i_inst.b.funct3;
                o_dec.ex.branch  = 1'b1;
            end
            // Address = rs1 + imm, size and sign kept for write-back
            op_load: begin
                o_dec.rs1_addr       = i_inst.i.rs1;
                o_dec.rd_addr        = i_inst.i.rd;
                o_dec.ex.alu2        = imm_out;
                o_dec.ex.func_op     = alu_add;
                o_dec.mem.mem_read   = 1'b1;
                o_dec.mem.mem_funct3 = i_inst.i.funct3;
                o_dec.wb.wb_sel      = mem_rdata_out;
                o_dec.wb.mem_funct3  = i_inst.i.funct3;
                o_dec.wb.regf_we     = 1'b1;
            end
            // rs2 is the store data
            op_store: begin
                o_dec.rs1_addr       = i_inst.s.rs1;
                o_dec.rs2_addr       = i_inst.s.rs2;
                o_dec.ex.alu2        = imm_out;
                o_dec.ex.func_op     = alu_add;
                o_dec.mem.mem_write  = 1'b1;
                o_dec.mem.mem_funct3 = i_inst.s.funct3;
            end
            op_imm: begin
                o_dec.rs1_addr   = i_inst.i.rs1;
                o_dec.rd_addr    = i_inst.i.rd;
                o_dec.ex.alu2    = imm_out;
                o_dec.wb.wb_sel  = func_out;
                o_dec.wb.regf_we = 1'b1;
                unique case (i_inst.i.funct3)
                    F3_ADD:  o_dec.ex.func_op = alu_add;
                    F3_SLL:  o_dec.ex.func_op = alu_sll;
                    F3_SLT: begin
                        o_dec.ex.func_op  = blt;
                        o_dec.ex.func_sel = cmp_out;
                    end
                    F3_SLTU: begin
                        o_dec.ex.func_op  = bltu;
                        o_dec.ex.func_sel = cmp_out;
                    end
                    F3_XOR:  o_dec.ex.func_op = alu_xor;
                    // srai shares funct3 with srli, upper imm bits split them
                    F3_SR: begin
                        if (i_inst.r.funct7 == FUNCT7_ALT) begin
                            o_dec.ex.func_op = alu_sra;
                        end else begin
                            o_dec.ex.func_op = alu_srl;
                        end
                    end
                    F3_OR:   o_dec.ex.func_op = alu_or;
                    F3_AND:  o_dec.ex.func_op = alu_and;
                endcase
            end
            op_reg: begin
                o_dec.rs1_addr   = i_inst.r.rs1;
                o_dec.rs2_addr   = i_inst.r.rs2;
                o_dec.rd_addr    = i_inst.r.rd;
                o_dec.wb.wb_sel  = func_out;
                o_dec.wb.regf_we = 1'b1;
                if (i_inst.r.funct7 == FUNCT7_MULDIV) begin
                    // M extension
                    unique case (i_inst.r.funct3)
                        F3_MUL, F3_MULH: o_dec.ex.func_op = ss_mul;
                        F3_MULHSU:       o_dec.ex.func_op = su_mul;
                        F3_MULHU:        o_dec.ex.func_op = uu_mul;
                        F3_DIV:          o_dec.ex.func_op = ss_div;
                        F3_DIVU:         o_dec.ex.func_op = uu_div;
                        F3_REM:          o_dec.ex.func_op = ss_rem;
                        F3_REMU:         o_dec.ex.func_op = uu_rem;
                    endcase
                    // Upper funct3 bit picks divider over multiplier
                    o_dec.ex.func_sel = i_inst.r.funct3[2] ? div_out : mul_out;
                end else begin
                    unique case (i_inst.r.funct3)
                        F3_ADD: begin
                            if (i_inst.r.funct7 == FUNCT7_ALT) begin
                                o_dec.ex.func_op = alu_sub;
                            end else begin
                                o_dec.ex.func_op = alu_add;
                            end
                        end
                        F3_SLL:  o_dec.ex.func_op = alu_sll;
                        F3_SLT: begin
                            o_dec.ex.func_op  = blt;
                            o_dec.ex.func_sel = cmp_out;
                        end
                        F3_SLTU: begin
                            o_dec.ex.func_op  = bltu;
                            o_dec.ex.func_sel = cmp_out;
                        end
                        F3_XOR:  o_dec.ex.func_op = alu_xor;
                        F3_SR: begin
                            if (i_inst.r.funct7 == FUNCT7_ALT) begin
                                o_dec.ex.func_op = alu_sra;
                            end else begin
                                o_dec.ex.func_op = alu_srl;
                            end
                        end
                        F3_OR:   o_dec.ex.func_op = alu_or;
                        F3_AND:  o_dec.ex.func_op = alu_and;
                    endcase
                end
            end
            default: begin
            end
        endcase
    end

endmodule : ctrl_decoder

`default_nettype wire

/* decode/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  wire                                clk,
    input  wire                                i_rst_n,
    input  wire                                i_valid,
    input  wire rv32_ctrl_pkg::dec_ctrl_t      i_dec,
    input  wire [rv32_isa_pkg::XLEN-1:0]       i_imm,
    output logic                               o_valid,
    output rv32_ctrl_pkg::id_ex_t              o_id_ex
);

    import rv32_ctrl_pkg::*;

    id_ex_t id_ex_next;

    // Control bundle and immediate side by side
    assign id_ex_next = '{dec: i_dec, imm: i_imm};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_id_ex <= '0;
        end else begin
            o_valid <= i_valid;
            // Bubble goes out all zero, no write, no access, no branch
            if (i_valid) begin
                o_id_ex <= id_ex_next;
            end else begin
                o_id_ex <= '0;
            end
        end
    end

endmodule : id_ex_reg

`default_nettype wire

/* decode/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  wire rv32_isa_pkg::inst_t      i_inst,
    output logic                          o_valid,
    output rv32_ctrl_pkg::id_ex_t         o_id_ex
);

    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    dec_ctrl_t       dec;
    logic [XLEN-1:0] imm;

    // Immediate path, same word as the decoder
    imm_gen u_imm_gen (
        .i_inst (i_inst),
        .o_imm  (imm)
    );

    // Register addresses and control bundles
    ctrl_decoder u_ctrl_decoder (
        .i_inst (i_inst),
        .o_dec  (dec)
    );

    // One cycle to execute
    id_ex_reg u_id_ex_reg (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_dec   (dec),
        .i_imm   (imm),
        .o_valid (o_valid),
        .o_id_ex (o_id_ex)
    );

endmodule : id_stage

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    // Free-running clock, low at time zero
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset low from time zero, released 1 ns after the last reset edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;

    localparam int IMM_ROUNDS = 16;
    localparam int STREAM_LEN = 64;
    // Reset, immediates, arithmetic, memory, control flow, stream
    localparam int TEST_CYCLES = 10 + 10 * IMM_ROUNDS + 40 + 8 + 10 + STREAM_LEN + 1;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 10 + 1000;

    // Major opcodes as the ISA encodes them
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BR      = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_IMM     = 7'b0010011;
    localparam logic [6:0] OPC_REG     = 7'b0110011;
    // custom-0 opcode is never decoded
    localparam logic [6:0] OPC_UNKNOWN = 7'b0001011;

    localparam logic [6:0] OPCODES [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BR,
                                           OPC_LOAD, OPC_STORE, OPC_IMM, OPC_REG};
    localparam logic [2:0] LOAD_F3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    localparam logic [2:0] BR_F3   [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // Base, alternate, M extension
    localparam logic [6:0] F7_TBL  [3] = '{7'h00, 7'h20, 7'h01};

    // funct3 to ALU code with compare slots filled by hand below
    localparam func_op_t ALU_TBL    [8] = '{alu_add, alu_sll, alu_add, alu_add,
                                            alu_xor, alu_srl, alu_or, alu_and};
    localparam func_op_t MULDIV_TBL [8] = '{ss_mul, ss_mul, su_mul, uu_mul,
                                            ss_div, uu_div, ss_rem, uu_rem};
    // funct3 to multiplier or divider port
    localparam func_sel_t MULDIV_SEL_TBL [8] = '{mul_out, mul_out, mul_out, mul_out,
                                                 div_out, div_out, div_out, div_out};

    logic   clk;
    logic   rst_n;
    logic   inst_valid;
    inst_t  inst_word;
    logic   dec_valid;
    id_ex_t dec_bundle;

    integer seed;
    // Last result expected on the outputs
    logic   prev_valid;
    id_ex_t prev_exp;

    tb_clk_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (8)
    ) u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    id_stage uut (
        .clk     (clk),
        .i_rst_n (rst_n),
        .i_valid (inst_valid),
        .i_inst  (inst_word),
        .o_valid (dec_valid),
        .o_id_ex (dec_bundle)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic compare_bundle(input logic valid, input id_ex_t expected);
        check_value("o_valid", 32'(valid), 32'(dec_valid));
        check_value("o_id_ex.dec.rs1_addr", 32'(expected.dec.rs1_addr),
                    32'(dec_bundle.dec.rs1_addr));
        check_value("o_id_ex.dec.rs2_addr", 32'(expected.dec.rs2_addr),
                    32'(dec_bundle.dec.rs2_addr));
        check_value("o_id_ex.dec.rd_addr", 32'(expected.dec.rd_addr),
                    32'(dec_bundle.dec.rd_addr));
        check_value("o_id_ex.dec.ex", 32'(expected.dec.ex), 32'(dec_bundle.dec.ex));
        check_value("o_id_ex.dec.mem", 32'(expected.dec.mem), 32'(dec_bundle.dec.mem));
        check_value("o_id_ex.dec.wb", 32'(expected.dec.wb), 32'(dec_bundle.dec.wb));
        check_value("o_id_ex.imm", expected.imm, dec_bundle.imm);
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Random register and immediate bits under a fixed opcode and funct3
    function automatic logic [31:0] inst_with_fields(input logic [6:0] opc,
                                                     input logic [2:0] f3);
        logic [31:0] w;
        w        = next_random();
        w[14:12] = f3;
        w[6:0]   = opc;
        return w;
    endfunction

    // Reference decode straight from the raw instruction bits
    function automatic id_ex_t model_decode(input logic [31:0] w);
        id_ex_t      e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        // All-zero equals the default bundle
        e = '0;
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                e.dec.rd_addr    = w[11:7];
                e.dec.ex.alu2    = imm_out;
                e.dec.ex.func_op = alu_add;
                e.dec.wb.wb_sel  = func_out;
                e.dec.wb.regf_we = 1'b1;
                e.imm            = imm_u;
                if (opc == OPC_AUIPC) begin
                    e.dec.ex.alu1 = pc_out;
                end
            end
            OPC_JAL, OPC_JALR: begin
                e.dec.rd_addr     = w[11:7];
                e.dec.ex.func_op  = beq;
                e.dec.ex.func_sel = addr_out;
                e.dec.ex.branch   = 1'b1;
                e.dec.wb.wb_sel   = func_out;
                e.dec.wb.regf_we  = 1'b1;
                e.imm             = imm_j;
                // jalr compares rs1 with itself and jumps from rs1
                if (opc == OPC_JALR) begin
                    e.dec.rs1_addr      = w[19:15];
                    e.dec.rs2_addr      = w[19:15];
                    e.dec.ex.target_sel = rs1_op;
                    e.imm               = imm_i;
                end
            end
            OPC_BR: begin
                e.dec.rs1_addr   = w[19:15];
                e.dec.rs2_addr   = w[24:20];
                e.dec.ex.func_op = f3;
                e.dec.ex.branch  = 1'b1;
                e.imm            = imm_b;
            end
            OPC_LOAD: begin
                e.dec.rs1_addr       = w[19:15];
                e.dec.rd_addr        = w[11:7];
                e.dec.ex.alu2        = imm_out;
                e.dec.ex.func_op     = alu_add;
                e.dec.mem.mem_read   = 1'b1;
                e.dec.mem.mem_funct3 = f3;
                e.dec.wb.wb_sel      = mem_rdata_out;
                e.dec.wb.mem_funct3  = f3;
                e.dec.wb.regf_we     = 1'b1;
                e.imm                = imm_i;
            end
            OPC_STORE: begin
                e.dec.rs1_addr       = w[19:15];
                e.dec.rs2_addr       = w[24:20];
                e.dec.ex.alu2        = imm_out;
                e.dec.ex.func_op     = alu_add;
                e.dec.mem.mem_write  = 1'b1;
                e.dec.mem.mem_funct3 = f3;
                e.imm                = imm_s;
            end
            OPC_IMM, OPC_REG: begin
                e.dec.rs1_addr   = w[19:15];
                e.dec.rd_addr    = w[11:7];
                e.dec.wb.wb_sel  = func_out;
                e.dec.wb.regf_we = 1'b1;
                if (opc == OPC_IMM) begin
                    e.dec.ex.alu2 = imm_out;
                    e.imm         = imm_i;
                end else begin
                    e.dec.rs2_addr = w[24:20];
                end
                if (opc == OPC_REG && f7 == 7'h01) begin
                    e.dec.ex.func_sel = MULDIV_SEL_TBL[f3];
                    e.dec.ex.func_op  = MULDIV_TBL[f3];
                end else if (f3 == 3'd2 || f3 == 3'd3) begin
                    // Set-less-than through the comparator
                    e.dec.ex.func_sel = cmp_out;
                    e.dec.ex.func_op  = (f3 == 3'd2) ? blt : bltu;
                end else begin
                    e.dec.ex.func_op = ALU_TBL[f3];
                    // SUB only in OP and SRA in both groups
                    if (f7 == 7'h20 && f3 == 3'd5) begin
                        e.dec.ex.func_op = alu_sra;
                    end
                    if (f7 == 7'h20 && f3 == 3'd0 && opc == OPC_REG) begin
                        e.dec.ex.func_op = alu_sub;
                    end
                end
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    // Any decoded opcode with a funct3/funct7 the ISA defines
    function automatic logic [31:0] legal_inst();
        logic [31:0] r;
        logic [31:0] w;
        logic [6:0]  opc;
        logic [2:0]  f3;
        r   = next_random();
        opc = OPCODES[int'(r[7:0]) % 9];
        f3  = r[10:8];
        case (opc)
            OPC_LOAD:  f3 = LOAD_F3[int'(r[10:8]) % 5];
            OPC_STORE: f3 = 3'(int'(r[10:8]) % 3);
            OPC_BR:    f3 = BR_F3[int'(r[10:8]) % 6];
            OPC_JALR:  f3 = 3'd0;
            default: begin
            end
        endcase
        w = inst_with_fields(opc, f3);
        if (opc == OPC_REG) begin
            w[31:25] = F7_TBL[int'(r[12:11]) % 3];
        end
        if (opc == OPC_IMM && f3 == 3'd1) begin
            w[31:25] = 7'h00;
        end
        if (opc == OPC_IMM && f3 == 3'd5) begin
            w[31:25] = r[13] ? 7'h20 : 7'h00;
        end
        return w;
    endfunction

    // Called 1 ns after an edge with one word per cycle
    task automatic send(input logic valid, input logic [31:0] w);
        id_ex_t expected;
        expected = '0;
        if (valid) begin
            expected = model_decode(w);
        end
        inst_valid = valid;
        inst_word  = w;
        // Outputs hold the previous result until the next edge
        #4;
        compare_bundle(prev_valid, prev_exp);
        @(posedge clk);
        #1;
        compare_bundle(valid, expected);
        prev_valid = valid;
        prev_exp   = expected;
    endtask

    task automatic reset_behavior();
        // Valid lui on the bus while reset is low
        inst_valid = 1'b1;
        inst_word  = inst_with_fields(OPC_LUI, 3'd0);
        repeat (4) begin
            @(posedge clk);
            #1;
            compare_bundle(1'b0, '0);
        end
        wait (rst_n === 1'b1);
        inst_valid = 1'b0;
        @(posedge clk);
        #1;
        compare_bundle(1'b0, '0);
    endtask

    task automatic immediate_formats();
        logic [31:0] w;
        for (int k = 0; k < 10; k++) begin
            for (int n = 0; n < IMM_ROUNDS; n++) begin
                w      = next_random();
                w[6:0] = (k < 9) ? OPCODES[k] : OPC_UNKNOWN;
                // Alternate the sign bit
                w[31]  = n[0];
                send(1'b1, w);
            end
        end
    endtask

    task automatic arith_decode();
        logic [31:0] w;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 2; k++) begin
                w        = inst_with_fields(OPC_IMM, 3'(f3));
                w[31:25] = (k == 0) ? 7'h00 : 7'h20;
                send(1'b1, w);
            end
            for (int k = 0; k < 3; k++) begin
                w        = inst_with_fields(OPC_REG, 3'(f3));
                w[31:25] = F7_TBL[k];
                send(1'b1, w);
            end
        end
    endtask

    task automatic memory_access();
        for (int k = 0; k < 5; k++) begin
            send(1'b1, inst_with_fields(OPC_LOAD, LOAD_F3[k]));
        end
        for (int k = 0; k < 3; k++) begin
            send(1'b1, inst_with_fields(OPC_STORE, 3'(k)));
        end
    endtask

    task automatic control_flow();
        for (int k = 0; k < 6; k++) begin
            send(1'b1, inst_with_fields(OPC_BR, BR_F3[k]));
        end
        send(1'b1, inst_with_fields(OPC_JAL, 3'd5));
        send(1'b1, inst_with_fields(OPC_JALR, 3'd0));
        send(1'b1, inst_with_fields(OPC_LUI, 3'd3));
        send(1'b1, inst_with_fields(OPC_AUIPC, 3'd6));
    endtask

    task automatic back_to_back_stream();
        logic [31:0] r;
        for (int n = 0; n < STREAM_LEN; n++) begin
            r = next_random();
            // Roughly one bubble in four with a live word still on the bus
            send(r[1:0] != 2'b00, legal_inst());
        end
        send(1'b0, legal_inst());
    endtask

    initial begin
        seed       = 76;
        inst_valid = 1'b0;
        inst_word  = '0;
        prev_valid = 1'b0;
        prev_exp   = '0;
        reset_behavior();
        immediate_formats();
        arith_decode();
        memory_access();
        control_flow();
        back_to_back_stream();
        $display("TB PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : tb_id_stage

`default_nettype wire

/* list.f */
common/rv32_isa_pkg.sv
common/rv32_ctrl_pkg.sv
decode/imm_gen.sv
decode/ctrl_decoder.sv
decode/id_ex_reg.sv
decode/id_stage.sv
testbench/tb_clk_gen.sv
testbench/tb_id_stage.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_id_stage &&
./obj_dir/Vtb_id_stage || exit 1
